//--- vseq_pkg.sv
// Types and helpers shared by the issue sequencer RTL and its testbench, imported by wildcard
package vseq_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Number of instruction IDs that can be in flight at the same time
  localparam int unsigned NrVInsn = 8;
  // ALU, load, store and slide
  localparam int unsigned NrUnits = 4;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0]                 vreg_t;
  typedef logic [15:0]                vlen_t;
  typedef logic [NrVInsn-1:0]         vid_mask_t;
  typedef logic [NrUnits-1:0]         unit_mask_t;

  // A masked instruction always takes its mask from v0
  localparam vreg_t VMaskReg = 5'd0;

  ////////////////////////////////////////
  // Operations and units
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VMV,        // No vector source operands
    VLE,
    VSE,
    VSLIDEUP,
    VSLIDEDOWN
  } op_e;

  // The unit encoding doubles as the row index of the running table and of unit_done_t
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_SLIDE
  } unit_e;

  ////////////////////////////////////////
  // Interface structs
  ////////////////////////////////////////

  // Request from the dispatcher, vm is high when the instruction is unmasked
  typedef struct packed {
    op_e   op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    logic  vm;
    vlen_t vl;
  } vseq_req_t;

  // Each vector holds one bit per ID the instruction has to wait for on that operand
  typedef struct packed {
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vm;
    vid_mask_t hazard_vd;
  } hazard_t;

  // Request handed to the processing elements
  typedef struct packed {
    vid_t    id;
    op_e     op;
    unit_e   unit;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    logic    vm;
    vlen_t   vl;
    hazard_t hazard;
  } pe_req_t;

  typedef struct packed {
    logic  error;
    vlen_t error_vl;
  } vseq_resp_t;

  // Row u lists the IDs that unit u finished in this cycle
  typedef vid_mask_t [NrUnits-1:0] unit_done_t;

  // Maps an operation onto the unit that executes it
  function automatic unit_e unit_of(op_e op);
    unit_e unit;
    case (op)
      VLE:                  unit = UNIT_LOAD;
      VSE:                  unit = UNIT_STORE;
      VSLIDEUP, VSLIDEDOWN: unit = UNIT_SLIDE;
      default:              unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

//--- vseq_running.sv
// Tracks which instruction ID runs on which unit, hands out the lowest free ID and flags idle
`timescale 1ns/1ps

module vseq_running import vseq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Issue strobe from the FSM
  input  logic       issue_i,
  input  unit_e      issue_unit_i,
  input  vid_t       issue_id_i,
  // Completion from the units
  input  unit_done_t unit_done_i,
  // Allocation and status
  output vid_t       next_id_o,
  output logic       ids_full_o,
  output vid_mask_t  running_o,
  output logic       idle_o
);

  // One row per unit, a set bit means that ID is still busy on that unit
  unit_done_t run_table_q, run_table_d;
  // The table with this cycle's done bits already removed
  unit_done_t run_table_ret;

  ////////////////////////////////////////
  // Retire and issue
  ////////////////////////////////////////

  always_comb begin : p_retire
    running_o = '0;
    for (int unsigned u = 0; u < NrUnits; u++) begin
      run_table_ret[u] = run_table_q[u] & ~unit_done_i[u];
      // Hazards and allocation both look at the vector after retirement
      running_o |= run_table_ret[u];
    end
  end

  always_comb begin : p_issue
    run_table_d = run_table_ret;
    // The new ID lands on the row of its unit, a done bit in the same cycle does not touch it
    if (issue_i) begin
      run_table_d[issue_unit_i][issue_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_table_q <= '0;
    end else begin
      run_table_q <= run_table_d;
    end
  end

  ////////////////////////////////////////
  // Free ID search
  ////////////////////////////////////////

  // Scan from the top so the lowest clear bit is the last one written
  always_comb begin : p_next_id
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign ids_full_o = &running_o;

  // Idle means nothing is left in the registered table
  assign idle_o = ~|run_table_q;

  // The FSM has to respect ids_full, so an issued ID is never one that is still busy
  a_no_busy_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_i |-> !running_o[issue_id_i])
    else $error("ID %0d issued while still running", issue_id_i);

endmodule

//--- vseq_hazard.sv
// Keeps the per-register reader and writer lists and builds the hazard vectors of the request
`timescale 1ns/1ps

module vseq_hazard import vseq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Request under issue and its ID
  input  vseq_req_t req_i,
  input  logic      issue_i,
  input  vid_t      issue_id_i,
  // Running IDs after this cycle's done bits
  input  vid_mask_t running_i,
  output hazard_t   hazards_o
);

  // Last instruction that touched a vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_entry_t;

  vreg_entry_t [31:0] read_list_q, read_list_d;
  vreg_entry_t [31:0] write_list_q, write_list_d;
  // Lists with the entries of finished instructions dropped
  vreg_entry_t [31:0] read_live, write_live;

  ////////////////////////////////////////
  // Entry retirement
  ////////////////////////////////////////

  // An entry stays only as long as its owner is running somewhere
  always_comb begin : p_live
    read_live  = read_list_q;
    write_live = write_list_q;
    for (int unsigned v = 0; v < 32; v++) begin
      read_live[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_live[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
  end

  ////////////////////////////////////////
  // Hazard vectors
  ////////////////////////////////////////

  always_comb begin : p_hazards
    vreg_entry_t wr_vs1;
    vreg_entry_t wr_vs2;
    vreg_entry_t wr_vm;
    vreg_entry_t wr_vd;
    vreg_entry_t rd_vd;
    wr_vs1    = write_live[req_i.vs1];
    wr_vs2    = write_live[req_i.vs2];
    wr_vm     = write_live[VMaskReg];
    wr_vd     = write_live[req_i.vd];
    rd_vd     = read_live[req_i.vd];
    hazards_o = '0;

    // RAW on the sources, and on v0 when the instruction is masked
    if (req_i.use_vs1) hazards_o.hazard_vs1[wr_vs1.vid] |= wr_vs1.valid;
    if (req_i.use_vs2) hazards_o.hazard_vs2[wr_vs2.vid] |= wr_vs2.valid;
    if (!req_i.vm) hazards_o.hazard_vm[wr_vm.vid] |= wr_vm.valid;

    if (req_i.use_vd) begin
      // WAR
      // The reader of vd may still need any of its operands, so every source vector waits
      hazards_o.hazard_vs1[rd_vd.vid] |= rd_vd.valid;
      hazards_o.hazard_vs2[rd_vd.vid] |= rd_vd.valid;
      hazards_o.hazard_vm[rd_vd.vid]  |= rd_vd.valid;
      // WAW
      hazards_o.hazard_vd[wr_vd.vid]  |= wr_vd.valid;
    end
  end

  ////////////////////////////////////////
  // List update
  ////////////////////////////////////////

  always_comb begin : p_update
    read_list_d  = read_live;
    write_list_d = write_live;
    if (issue_i) begin
      // The issued instruction becomes the newest owner of every register it touches
      if (req_i.use_vd) write_list_d[req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs1) read_list_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs2) read_list_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      if (!req_i.vm) read_list_d[VMaskReg] = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule

//--- vseq_queue_cnt.sv
// Counts the instructions queued at each execution unit and reports which units can take more
`timescale 1ns/1ps

module vseq_queue_cnt import vseq_pkg::*; #(
  // Instructions a unit can hold before it stalls issue, 1 to 7
  parameter int unsigned QueueDepth = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       issue_i,
  input  unit_e      issue_unit_i,
  input  unit_done_t unit_done_i,
  output unit_mask_t unit_ready_o
);

  // Wide enough to hold QueueDepth itself
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_unit_cnt
    cnt_t cnt_q;
    logic cnt_up;
    logic cnt_down;

    // Counted at issue, there is no early reservation on arrival
    assign cnt_up   = issue_i && (issue_unit_i == unit_e'(u));
    // Any finished ID on this unit frees one slot
    assign cnt_down = |unit_done_i[u];

    // Issue and done in the same cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end

    assign unit_ready_o[u] = cnt_q < cnt_t'(QueueDepth);

    // The FSM only issues to a ready unit, so the queue never overfills
    a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q <= cnt_t'(QueueDepth))
      else $error("Unit %0d queue count %0d above depth", u, cnt_q);

    // A unit cannot report work done that was never issued to it
    a_cnt_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_down && !cnt_up) |-> (cnt_q != '0))
      else $error("Unit %0d reported done with an empty queue", u);
  end

endmodule

//--- vseq_fsm.sv
// Decides stall or issue for each dispatcher request, holds the PE request and answers memory ops
`timescale 1ns/1ps

module vseq_fsm import vseq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Dispatcher
  input  vseq_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output vseq_resp_t resp_o,
  output logic       resp_valid_o,
  // Processing elements
  output pe_req_t    pe_req_o,
  output logic       pe_req_valid_o,
  input  logic       pe_req_ready_i,
  // Address generator
  input  logic       addrgen_ack_i,
  input  logic       addrgen_error_i,
  input  vlen_t      addrgen_error_vl_i,
  // Bookkeeping from the other blocks
  input  vid_t       next_id_i,
  input  logic       ids_full_i,
  input  unit_mask_t unit_ready_i,
  input  hazard_t    hazards_i,
  output logic       issue_o,
  output unit_e      issue_unit_o
);

  // WAIT holds a load or store until the address generator answers
  typedef enum logic {IDLE, WAIT} state_e;

  state_e  state_q, state_d;
  pe_req_t pe_req_d;
  logic    pe_req_valid_d;

  unit_e req_unit;
  logic  is_mem;
  logic  has_operands;
  logic  any_hazard;
  logic  slide_hazard;
  logic  stall;

  ////////////////////////////////////////
  // Stall rules
  ////////////////////////////////////////

  assign req_unit     = unit_of(req_i.op);
  assign issue_unit_o = req_unit;
  assign is_mem       = (req_unit == UNIT_LOAD) || (req_unit == UNIT_STORE);
  // v0 counts as an operand when the instruction is masked
  assign has_operands = req_i.use_vs1 || req_i.use_vs2 || !req_i.vm;
  assign any_hazard   = |{hazards_i.hazard_vs1, hazards_i.hazard_vs2,
                          hazards_i.hazard_vm, hazards_i.hazard_vd};

  // Slides move elements across lanes and cannot chain behind their producers
  assign slide_hazard = (req_unit == UNIT_SLIDE) && any_hazard;

  // Loads are let through even without operands since the load unit orders its own writes
  assign stall = ids_full_i || !unit_ready_i[req_unit] || slide_hazard ||
                 (!has_operands && any_hazard && (req_unit != UNIT_LOAD));

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin : p_fsm
    state_d  = state_q;
    pe_req_d = pe_req_o;
    // A request accepted by the PEs this cycle drops out
    pe_req_valid_d = pe_req_valid_o && !pe_req_ready_i;
    req_ready_o    = 1'b1;
    resp_o         = '0;
    resp_valid_o   = 1'b0;
    issue_o        = 1'b0;

    case (state_q)
      IDLE: begin
        if (pe_req_valid_o && !pe_req_ready_i) begin
          // The PEs are still busy with the last request so it is kept and nothing new is taken
          req_ready_o = 1'b0;
        end else if (req_valid_i) begin
          if (stall) begin
            req_ready_o = 1'b0;
          end else begin
            issue_o        = 1'b1;
            pe_req_valid_d = 1'b1;
            pe_req_d       = '{
              id     : next_id_i,
              op     : req_i.op,
              unit   : req_unit,
              vs1    : req_i.vs1,
              vs2    : req_i.vs2,
              vd     : req_i.vd,
              vm     : req_i.vm,
              vl     : req_i.vl,
              hazard : hazards_i
            };
            // Memory ops are already issued but the dispatcher waits for the address check
            if (is_mem) begin
              req_ready_o = 1'b0;
              state_d     = WAIT;
            end
          end
        end
      end

      WAIT: begin
        req_ready_o = 1'b0;
        if (addrgen_ack_i) begin
          req_ready_o     = 1'b1;
          resp_valid_o    = 1'b1;
          resp_o.error    = addrgen_error_i;
          resp_o.error_vl = addrgen_error_vl_i;
          state_d         = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_o       <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_o       <= pe_req_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  // Under back-pressure the PE request must neither drop nor change
  a_pe_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pe_req_valid_o && !pe_req_ready_i) |=> (pe_req_valid_o && $stable(pe_req_o)))
    else $error("PE request changed while held under back-pressure");

endmodule

//--- vseq_top.sv
// Top level of the issue sequencer, instantiated by the vector processor or the testbench
`timescale 1ns/1ps

module vseq_top import vseq_pkg::*; #(
  // Depth of every unit queue, 1 to 7
  parameter int unsigned QueueDepth = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Dispatcher
  input  vseq_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output vseq_resp_t resp_o,
  output logic       resp_valid_o,
  // Processing elements
  output pe_req_t    pe_req_o,
  output logic       pe_req_valid_o,
  input  logic       pe_req_ready_i,
  input  unit_done_t unit_done_i,
  // Address generator
  input  logic       addrgen_ack_i,
  input  logic       addrgen_error_i,
  input  vlen_t      addrgen_error_vl_i,
  output logic       idle_o
);

  vid_t       next_id;
  logic       ids_full;
  vid_mask_t  running;
  hazard_t    hazards;
  unit_mask_t unit_ready;
  logic       issue;
  unit_e      issue_unit;

  // The issued ID is always the free ID offered in the same cycle
  vseq_running vseq_running_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (issue_unit),
    .issue_id_i   (next_id),
    .unit_done_i  (unit_done_i),
    .next_id_o    (next_id),
    .ids_full_o   (ids_full),
    .running_o    (running),
    .idle_o       (idle_o)
  );

  vseq_hazard vseq_hazard_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .issue_i    (issue),
    .issue_id_i (next_id),
    .running_i  (running),
    .hazards_o  (hazards)
  );

  vseq_queue_cnt #(
    .QueueDepth (QueueDepth)
  ) vseq_queue_cnt_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (issue_unit),
    .unit_done_i  (unit_done_i),
    .unit_ready_o (unit_ready)
  );

  vseq_fsm vseq_fsm_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req_i),
    .req_valid_i        (req_valid_i),
    .req_ready_o        (req_ready_o),
    .resp_o             (resp_o),
    .resp_valid_o       (resp_valid_o),
    .pe_req_o           (pe_req_o),
    .pe_req_valid_o     (pe_req_valid_o),
    .pe_req_ready_i     (pe_req_ready_i),
    .addrgen_ack_i      (addrgen_ack_i),
    .addrgen_error_i    (addrgen_error_i),
    .addrgen_error_vl_i (addrgen_error_vl_i),
    .next_id_i          (next_id),
    .ids_full_i         (ids_full),
    .unit_ready_i       (unit_ready),
    .hazards_i          (hazards),
    .issue_o            (issue),
    .issue_unit_o       (issue_unit)
  );

endmodule

//--- tb_vseq_table.svh
// Cycle table of the sequencer testbench, included in its module body and loaded before the run
// Row columns are request, unit done bits with ALU in the low byte, addrgen answer, pe_req_ready_i,
// then expected {req_ready, pe_req_valid, resp_valid, idle}, PE ID, hazards and response
// Hazard words read {vs1, vs2, vm, vd} from the top byte down
task automatic load_steps();
  // Two ALU ops and a slide take IDs 0 to 2, then the freed ID 1 is handed out again
  start_test("ids");
  add_step(vreq(VADD, 1, 2, 3, 7, 1), 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
  add_step(vreq(VSUB, 4, 5, 6, 7, 1), 'h0, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  add_step(vreq(VSLIDEDOWN, 0, 7, 8, 3, 1), 'h0, NoAck, 1, 4'b1100, 1, 'h0, 'h0);
  add_step(NoReq, 'h00000002, NoAck, 1, 4'b1100, 2, 'h0, 'h0);
  add_step(vreq(VAND, 9, 10, 11, 7, 1), 'h0, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h04000001, NoAck, 1, 4'b1100, 1, 'h0, 'h0);
  add_step(NoReq, 'h00000002, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  // RAW on vs1, WAR on vd and a masked read of v0
  start_test("hazards");
  add_step(vreq(VADD, 1, 2, 3, 7, 1), 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
  add_step(vreq(VADD, 3, 4, 5, 7, 1), 'h0, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  add_step(NoReq, 'h00000001, NoAck, 1, 4'b1100, 1, 'h01000000, 'h0);
  add_step(vreq(VSUB, 6, 7, 4, 7, 1), 'h0, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h00000002, NoAck, 1, 4'b1100, 0, 'h02020200, 'h0);
  add_step(vreq(VADD, 8, 9, 0, 7, 1), 'h0, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h00000001, NoAck, 1, 4'b1100, 1, 'h0, 'h0);
  add_step(vreq(VAND, 10, 11, 12, 7, 0), 'h0, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h00000002, NoAck, 1, 4'b1100, 0, 'h00000200, 'h0);
  add_step(NoReq, 'h00000001, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  // The load is held until the address generator answers with an error
  start_test("load_wait");
  add_step(vreq(VLE, 0, 0, 2, 1, 1), 'h0, NoAck, 1, 4'b0001, 0, 'h0, 'h0);
  add_step(vreq(VLE, 0, 0, 2, 1, 1), 'h0, NoAck, 1, 4'b0100, 0, 'h0, 'h0);
  add_step(vreq(VLE, 0, 0, 2, 1, 1), 'h0, ack_with(1, 5), 1, 4'b1010, 0, 'h0, 'h10005);
  add_step(NoReq, 'h00000100, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  // The third slide waits for a free slot in the slide queue
  start_test("queue_full");
  add_step(vreq(VSLIDEUP, 0, 1, 2, 3, 1), 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
  add_step(vreq(VSLIDEUP, 0, 3, 4, 3, 1), 'h0, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  add_step(vreq(VSLIDEDOWN, 0, 5, 6, 3, 1), 'h0, NoAck, 1, 4'b0100, 1, 'h0, 'h0);
  add_step(vreq(VSLIDEDOWN, 0, 5, 6, 3, 1), 'h01000000, NoAck, 1, 4'b0000, 0, 'h0, 'h0);
  add_step(vreq(VSLIDEDOWN, 0, 5, 6, 3, 1), 'h0, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h02000000, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  add_step(NoReq, 'h01000000, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  // A slide and a VMV stall on their hazard until the producer is done
  start_test("slide_stall");
  add_step(vreq(VADD, 1, 2, 3, 7, 1), 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
  add_step(vreq(VSLIDEUP, 0, 3, 4, 3, 1), 'h0, NoAck, 1, 4'b0100, 0, 'h0, 'h0);
  add_step(vreq(VSLIDEUP, 0, 3, 4, 3, 1), 'h00000001, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h01000000, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  add_step(vreq(VADD, 5, 6, 7, 7, 1), 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
  add_step(vreq(VMV, 0, 0, 7, 1, 1), 'h0, NoAck, 1, 4'b0100, 0, 'h0, 'h0);
  add_step(vreq(VMV, 0, 0, 7, 1, 1), 'h0, NoAck, 1, 4'b0000, 0, 'h0, 'h0);
  add_step(vreq(VMV, 0, 0, 7, 1, 1), 'h00000001, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h00000001, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  // The PE request is held while the PEs are not ready, then idle returns
  start_test("backpressure");
  add_step(vreq(VADD, 1, 2, 3, 7, 1), 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
  add_step(vreq(VSUB, 4, 5, 6, 7, 1), 'h0, NoAck, 0, 4'b0100, 0, 'h0, 'h0);
  add_step(vreq(VSUB, 4, 5, 6, 7, 1), 'h0, NoAck, 0, 4'b0100, 0, 'h0, 'h0);
  add_step(vreq(VSUB, 4, 5, 6, 7, 1), 'h0, NoAck, 1, 4'b1100, 0, 'h0, 'h0);
  add_step(NoReq, 'h00000001, NoAck, 1, 4'b1100, 1, 'h0, 'h0);
  add_step(NoReq, 'h00000002, NoAck, 1, 4'b1000, 0, 'h0, 'h0);
  add_step(NoReq, 'h0, NoAck, 1, 4'b1001, 0, 'h0, 'h0);
endtask

//--- tb_vseq.sv
// Self-checking testbench for the issue sequencer that replays a cycle table and reports each test
`timescale 1ns/1ps

module tb_vseq import vseq_pkg::*; ();

  ////////////////////////////////////////
  // Step table types
  ////////////////////////////////////////

  // Dispatcher side of one cycle
  typedef struct packed {
    logic      valid;
    vseq_req_t req;
  } dispatch_t;

  // Address generator answer of one cycle
  typedef struct packed {
    logic  ack;
    logic  error;
    vlen_t error_vl;
  } addrgen_t;

  // Flags hold the expected {req_ready_o, pe_req_valid_o, resp_valid_o, idle_o}
  typedef struct packed {
    dispatch_t  disp;
    unit_done_t done;
    addrgen_t   addrgen;
    logic       pe_ready;
    logic [3:0] flags;
    vid_t       id;
    hazard_t    hazard;
    vseq_resp_t resp;
  } step_t;

  localparam dispatch_t NoReq = '0;
  localparam addrgen_t  NoAck = '0;

  logic       clk_i;
  logic       rst_ni;
  vseq_req_t  req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  vseq_resp_t resp_o;
  logic       resp_valid_o;
  pe_req_t    pe_req_o;
  logic       pe_req_valid_o;
  logic       pe_req_ready_i;
  unit_done_t unit_done_i;
  logic       addrgen_ack_i;
  logic       addrgen_error_i;
  vlen_t      addrgen_error_vl_i;
  logic       idle_o;

  step_t       steps[$];
  string       step_names[$];
  string       cur_test;
  int unsigned cycle_limit;
  int unsigned cycle_cnt;
  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned test_cnt;

  vseq_top #(
    .QueueDepth (2)
  ) vseq_top_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req_i),
    .req_valid_i        (req_valid_i),
    .req_ready_o        (req_ready_o),
    .resp_o             (resp_o),
    .resp_valid_o       (resp_valid_o),
    .pe_req_o           (pe_req_o),
    .pe_req_valid_o     (pe_req_valid_o),
    .pe_req_ready_i     (pe_req_ready_i),
    .unit_done_i        (unit_done_i),
    .addrgen_ack_i      (addrgen_ack_i),
    .addrgen_error_i    (addrgen_error_i),
    .addrgen_error_vl_i (addrgen_error_vl_i),
    .idle_o             (idle_o)
  );

  ////////////////////////////////////////
  // Table building
  ////////////////////////////////////////

  // Uses is {use_vs1, use_vs2, use_vd}
  // Every request carries the same vector length
  function automatic dispatch_t vreq(op_e op, vreg_t vs1, vreg_t vs2, vreg_t vd,
                                     logic [2:0] uses, logic vm);
    dispatch_t d;
    d.valid       = 1'b1;
    d.req.op      = op;
    d.req.vs1     = vs1;
    d.req.use_vs1 = uses[2];
    d.req.vs2     = vs2;
    d.req.use_vs2 = uses[1];
    d.req.vd      = vd;
    d.req.use_vd  = uses[0];
    d.req.vm      = vm;
    d.req.vl      = 16'd16;
    return d;
  endfunction

  function automatic addrgen_t ack_with(logic error, vlen_t error_vl);
    addrgen_t a;
    a.ack      = 1'b1;
    a.error    = error;
    a.error_vl = error_vl;
    return a;
  endfunction

  task automatic start_test(string name);
    cur_test = name;
  endtask

  task automatic add_step(dispatch_t disp, unit_done_t done, addrgen_t addrgen, logic pe_ready,
                          logic [3:0] flags, vid_t id, hazard_t hazard, vseq_resp_t resp);
    step_t s;
    s.disp     = disp;
    s.done     = done;
    s.addrgen  = addrgen;
    s.pe_ready = pe_ready;
    s.flags    = flags;
    s.id       = id;
    s.hazard   = hazard;
    s.resp     = resp;
    steps.push_back(s);
    step_names.push_back(cur_test);
  endtask

  `include "tb_vseq_table.svh"

  ////////////////////////////////////////
  // Drive and compare
  ////////////////////////////////////////

  task automatic drive_step(step_t s);
    req_valid_i        = s.disp.valid;
    req_i              = s.disp.req;
    unit_done_i        = s.done;
    addrgen_ack_i      = s.addrgen.ack;
    addrgen_error_i    = s.addrgen.error;
    addrgen_error_vl_i = s.addrgen.error_vl;
    pe_req_ready_i     = s.pe_ready;
  endtask

  // Arithmetic ops and VMV run on the ALU, loads and stores on their own units
  function automatic unit_e expected_unit(op_e op);
    unit_e unit;
    case (op)
      VADD, VSUB, VAND, VMV: unit = UNIT_ALU;
      VLE:                   unit = UNIT_LOAD;
      VSE:                   unit = UNIT_STORE;
      default:               unit = UNIT_SLIDE;
    endcase
    return unit;
  endfunction

  task automatic check_bit(string name, string what, logic exp, logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s %s: expected %0b, actual %0b", name, what, exp, act);
    end
  endtask

  task automatic check_pe_req(string name, pe_req_t exp, pe_req_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s pe_req_o: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(string name, vseq_resp_t exp, vseq_resp_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s resp_o: expected error %0b vl %0d, actual error %0b vl %0d",
               name, exp.error, exp.error_vl, act.error, act.error_vl);
    end
  endtask

  // ID and hazards come from the table and the other fields from the issued request
  task automatic compare_step(string name, step_t s, vseq_req_t src);
    pe_req_t exp_pe;
    exp_pe.id     = s.id;
    exp_pe.op     = src.op;
    exp_pe.unit   = expected_unit(src.op);
    exp_pe.vs1    = src.vs1;
    exp_pe.vs2    = src.vs2;
    exp_pe.vd     = src.vd;
    exp_pe.vm     = src.vm;
    exp_pe.vl     = src.vl;
    exp_pe.hazard = s.hazard;
    check_bit(name, "req_ready_o", s.flags[3], req_ready_o);
    check_bit(name, "pe_req_valid_o", s.flags[2], pe_req_valid_o);
    check_bit(name, "resp_valid_o", s.flags[1], resp_valid_o);
    check_bit(name, "idle_o", s.flags[0], idle_o);
    // Payloads carry meaning only while their valid is high
    if (s.flags[2]) check_pe_req(name, exp_pe, pe_req_o);
    if (s.flags[1]) check_resp(name, s.resp, resp_o);
  endtask

  ////////////////////////////////////////
  // Clock, watchdog and main sequence
  ////////////////////////////////////////

  initial begin : p_clock
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // The limit is set once the table is loaded and leaves ample room over one cycle per step
  initial begin : p_watchdog
    cycle_cnt = 0;
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the step table did not run to its end", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  initial begin : p_main
    int unsigned test_errs;
    int unsigned test_steps;
    vseq_req_t   issued_req;
    req_i              = '0;
    req_valid_i        = 1'b0;
    pe_req_ready_i     = 1'b1;
    unit_done_i        = '0;
    addrgen_ack_i      = 1'b0;
    addrgen_error_i    = 1'b0;
    addrgen_error_vl_i = '0;
    rst_ni             = 1'b0;
    test_errs          = 0;
    test_steps         = 0;
    issued_req         = '0;
    load_steps();
    cycle_limit = steps.size() * 4 + 100;

    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // One table row is driven per cycle and sampled halfway through it
    for (int k = 0; k < steps.size(); k++) begin
      @(posedge clk_i);
      #1;
      drive_step(steps[k]);
      // A valid PE request that was not held under back-pressure comes from the previous row
      if (k > 0 && steps[k].flags[2] &&
          !(steps[k - 1].flags[2] && !steps[k - 1].pe_ready)) begin
        issued_req = steps[k - 1].disp.req;
      end
      #4;
      compare_step($sformatf("%s step %0d", step_names[k], k), steps[k], issued_req);
      test_steps++;
      if (k == steps.size() - 1 || step_names[k + 1] != step_names[k]) begin
        test_cnt++;
        $display("Test %s finished, %0d steps, %0d errors",
                 step_names[k], test_steps, err_cnt - test_errs);
        test_errs  = err_cnt;
        test_steps = 0;
      end
    end

    @(posedge clk_i);
    $display("Summary %0d tests, %0d steps, %0d checks, %0d errors",
             test_cnt, steps.size(), check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
vseq_pkg.sv
vseq_running.sv
vseq_hazard.sv
vseq_queue_cnt.sv
vseq_fsm.sv
vseq_top.sv
tb_vseq.sv

//--- Bender.yml
package:
  name: vseq

sources:
  - vseq_pkg.sv
  - vseq_running.sv
  - vseq_hazard.sv
  - vseq_queue_cnt.sv
  - vseq_fsm.sv
  - vseq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vseq.sv
